//--- hdl/eth_defs_pkg.sv
/*
 * Ethernet protocol constants for the receive MAC
 */
package eth_defs_pkg;

    // ----------------------------------------
    // frame framing
    // ----------------------------------------

    // number of 0x55 bytes ahead of the delimiter
    localparam int PREAMBLE_LEN = 7;

    // byte position of the 0xD5 delimiter, data starts right after it
    localparam int SFD_POS = PREAMBLE_LEN;

    // frame check sequence length in bytes
    localparam int FCS_LEN = 4;

    // ----------------------------------------
    // CRC-32 (IEEE 802.3)
    // ----------------------------------------

    // polynomial 0x04C11DB7 in reflected (lsb first) form
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // register start value
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // register value left over after a clean frame including its FCS,
    // given in msb-first order
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

endpackage

//--- hdl/mac_rx_pkg.sv
/*
 * Receive MAC types: PHY byte, beat stream, output stream, link status
 */
package mac_rx_pkg;

    // ----------------------------------------
    // in-band link status
    // ----------------------------------------

    // rxc speed code as sent by the PHY, code 3 is reserved
    typedef enum logic [1:0] {
        SPEED_10M  = 2'd0,
        SPEED_100M = 2'd1,
        SPEED_1G   = 2'd2
    } link_speed_e;

    // field order follows the RGMII nibble: [3] duplex, [2:1] speed, [0] link
    typedef struct packed {
        logic        full_duplex;
        link_speed_e speed;
        logic        link_up;
    } link_status_t;

    // ----------------------------------------
    // stream types
    // ----------------------------------------

    // one byte from the DDR capture, with its control bits
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } rx_byte_t;

    // parser output, preamble and delimiter already stripped
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;
        logic       er;
    } rx_beat_t;

    // top level receive stream
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;
        logic       eof;
        logic       fr_good;
        logic       fr_err;
    } rx_out_t;

    // ----------------------------------------
    // pipeline
    // ----------------------------------------
    localparam int ALIGN_DEPTH = 2;
    localparam int RX_LATENCY  = 4;
    // frame position counter width, saturates well past the first data byte
    localparam int POS_W       = 4;

endpackage

//--- hdl/mac_rx_top.sv
/*
 * RGMII receive MAC top: parser, CRC checker and alignment buffer
 */
module mac_rx_top (
    input  logic                     mac_rx_clk,
    input  logic                     rst_n_i,
    input  mac_rx_pkg::rx_byte_t     rx_byte_i,
    output mac_rx_pkg::rx_out_t      mac_rx_o,
    output mac_rx_pkg::link_status_t status_o
);
    import mac_rx_pkg::*;

    // parser stream, shared by checker and buffer
    rx_beat_t beat;
    logic     frame_end;
    // verdict pulse from the checker
    logic     verdict_valid;
    logic     frame_good;
    logic     frame_err;

    // ----------------------------------------
    // producer
    // ----------------------------------------
    rx_frame_parser u_parser (
        .mac_rx_clk  (mac_rx_clk),
        .rst_n_i     (rst_n_i),
        .rx_byte_i   (rx_byte_i),
        .beat_o      (beat),
        .frame_end_o (frame_end),
        .status_o    (status_o)
    );

    // ----------------------------------------
    // frame check
    // ----------------------------------------
    rx_crc_check u_crc_check (
        .mac_rx_clk      (mac_rx_clk),
        .rst_n_i         (rst_n_i),
        .beat_i          (beat),
        .frame_end_i     (frame_end),
        .verdict_valid_o (verdict_valid),
        .frame_good_o    (frame_good),
        .frame_err_o     (frame_err)
    );

    // output alignment
    rx_align_buffer u_align (
        .mac_rx_clk      (mac_rx_clk),
        .rst_n_i         (rst_n_i),
        .beat_i          (beat),
        .verdict_valid_i (verdict_valid),
        .frame_good_i    (frame_good),
        .frame_err_i     (frame_err),
        .mac_rx_o        (mac_rx_o)
    );

endmodule

//--- hdl/rx_align_buffer.sv
/*
 * Receive alignment buffer: holds beats until the frame verdict exists,
 * then attaches eof and the verdict to the last byte
 */
module rx_align_buffer (
    input  logic                 mac_rx_clk,
    input  logic                 rst_n_i,
    input  mac_rx_pkg::rx_beat_t beat_i,
    input  logic                 verdict_valid_i,
    input  logic                 frame_good_i,
    input  logic                 frame_err_i,
    output mac_rx_pkg::rx_out_t  mac_rx_o
);
    import mac_rx_pkg::*;

    // shift line, index 0 is the newest beat
    rx_beat_t line_q [ALIGN_DEPTH];
    rx_beat_t tail;

    // beat about to leave the line
    assign tail = line_q[ALIGN_DEPTH-1];

    // ----------------------------------------
    // delay line
    // ----------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ALIGN_DEPTH; i++) begin
                line_q[i] <= '0;
            end
        end else begin
            line_q[0] <= beat_i;
            for (int i = 1; i < ALIGN_DEPTH; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------

    // verdict pulse lines up with the last byte at the tail
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mac_rx_o <= '0;
        end else begin
            mac_rx_o.data    <= tail.data;
            mac_rx_o.valid   <= tail.valid;
            mac_rx_o.sof     <= tail.sof;
            mac_rx_o.eof     <= verdict_valid_i;
            mac_rx_o.fr_good <= verdict_valid_i & frame_good_i;
            mac_rx_o.fr_err  <= verdict_valid_i & frame_err_i;
        end
    end

    // checker and parser timing must keep the verdict on a real byte
    a_verdict_on_tail : assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        verdict_valid_i |-> tail.valid
    );

endmodule

//--- hdl/rx_crc_check.sv
/*
 * Receive CRC checker: byte-wise CRC-32 over each frame and its FCS,
 * collects er and gives one verdict per frame
 */
module rx_crc_check (
    input  logic                 mac_rx_clk,
    input  logic                 rst_n_i,
    input  mac_rx_pkg::rx_beat_t beat_i,
    input  logic                 frame_end_i,
    output logic                 verdict_valid_o,
    output logic                 frame_good_o,
    output logic                 frame_err_o
);
    import eth_defs_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_seed;
    logic [31:0] crc_next;
    // register in msb-first order, matches the residue constant
    logic [31:0] crc_rev;
    logic        er_seen_q;

    // one byte through the reflected CRC, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                             input logic [7:0]  d);
        logic [31:0] c;
        c = crc ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // ----------------------------------------
    // CRC register
    // ----------------------------------------

    // sof restarts from all ones
    assign crc_seed = beat_i.sof ? CRC_INIT : crc_q;
    assign crc_next = crc_byte(crc_seed, beat_i.data);
    assign crc_rev  = {<<{crc_q}};

    always_ff @(posedge mac_rx_clk) begin
        if (beat_i.valid) begin
            crc_q <= crc_next;
        end
    end

    // sticky er over the data and FCS bytes
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            er_seen_q <= 1'b0;
        end else if (beat_i.valid) begin
            er_seen_q <= beat_i.er | (er_seen_q & ~beat_i.sof);
        end
    end

    // ----------------------------------------
    // verdict
    // ----------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            verdict_valid_o <= 1'b0;
            frame_good_o    <= 1'b0;
            frame_err_o     <= 1'b0;
        end else begin
            verdict_valid_o <= frame_end_i;
            frame_good_o    <= frame_end_i & (crc_rev == CRC_RESIDUE);
            frame_err_o     <= frame_end_i & er_seen_q;
        end
    end

    // the parser flags the end only once the beat burst has stopped
    a_end_after_burst : assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        frame_end_i |-> !beat_i.valid
    );

endmodule

//--- hdl/rx_frame_parser.sv
/*
 * Receive frame parser: strips preamble and SFD by position, emits the
 * beat stream and an end-of-frame pulse, and captures in-band link status
 */
module rx_frame_parser (
    input  logic                     mac_rx_clk,
    input  logic                     rst_n_i,
    input  mac_rx_pkg::rx_byte_t     rx_byte_i,
    output mac_rx_pkg::rx_beat_t     beat_o,
    output logic                     frame_end_o,
    output mac_rx_pkg::link_status_t status_o
);
    import mac_rx_pkg::*;
    import eth_defs_pkg::*;

    // registered PHY byte
    rx_byte_t         rx_q;
    // byte position inside the current frame
    logic [POS_W-1:0] pos_q;
    logic             first_data;
    logic             past_sfd;
    logic             pos_full;

    // ----------------------------------------
    // input register
    // ----------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_q <= '0;
        end else begin
            rx_q <= rx_byte_i;
        end
    end

    // ----------------------------------------
    // position counter
    // ----------------------------------------
    assign pos_full = &pos_q;

    // cleared through the whole gap, holds at all ones on long frames
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pos_q <= '0;
        end else if (!rx_q.dv) begin
            pos_q <= '0;
        end else if (!pos_full) begin
            pos_q <= pos_q + 1'b1;
        end
    end

    // first data byte sits right after the delimiter
    assign first_data = (pos_q == POS_W'(SFD_POS + 1));
    assign past_sfd   = (pos_q >  POS_W'(SFD_POS));

    // ----------------------------------------
    // beat stream
    // ----------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat_o      <= '0;
            frame_end_o <= 1'b0;
        end else begin
            beat_o.data  <= rx_q.data;
            beat_o.valid <= rx_q.dv & past_sfd;
            beat_o.sof   <= rx_q.dv & first_data;
            // er only counts inside the frame
            beat_o.er    <= rx_q.dv & rx_q.er;
            // first idle byte: pos_q still holds the frame length,
            // which must reach past the first data byte
            frame_end_o  <= ~rx_q.dv & (pos_q > POS_W'(SFD_POS + 1));
        end
    end

    // ----------------------------------------
    // link status during the interframe gap
    // ----------------------------------------

    // PHY repeats status in the low nibble while dv and er are both low
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_o <= '0;
        end else if (!rx_q.dv && !rx_q.er) begin
            status_o <= link_status_t'(rx_q.data[3:0]);
        end
    end

    // sof opens a burst of valid beats, never in the middle of one
    a_sof_opens_burst : assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        beat_o.sof |-> beat_o.valid && !$past(beat_o.valid)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the receive MAC testbench with Verilator
# exit status is nonzero when the testbench stops on an error
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_mac_rx \
    -Mdir obj_dir \
    -o sim_mac_rx

./obj_dir/sim_mac_rx

//--- tb/tb_frame_gen.svh
/*
 * Reference CRC-32 and Ethernet frame builder for the receive MAC testbench
 */
`ifndef TB_FRAME_GEN_SVH
`define TB_FRAME_GEN_SVH

typedef logic [7:0] byte_q_t[$];

// ----------------------------------------
// reference CRC-32
// ----------------------------------------

// msb-first register, data bits enter lsb first as they do on the wire
function automatic logic [31:0] crc_wire_byte(input logic [31:0] crc, input logic [7:0] d);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        fb = c[31] ^ d[i];
        c  = {c[30:0], 1'b0};
        if (fb) begin
            c = c ^ 32'h04C1_1DB7;
        end
    end
    return c;
endfunction

// FCS value, bit 0 is the first bit on the wire
function automatic logic [31:0] fcs_of(input byte_q_t body);
    logic [31:0] c;
    logic [31:0] fcs;
    c = 32'hFFFF_FFFF;
    foreach (body[i]) begin
        c = crc_wire_byte(c, body[i]);
    end
    // x^31 term goes out first, so it lands in bit 0
    for (int i = 0; i < 32; i++) begin
        fcs[i] = ~c[31-i];
    end
    return fcs;
endfunction

// ----------------------------------------
// frame builder
// ----------------------------------------

// preamble, SFD, payload, FCS low byte first
function automatic byte_q_t build_frame(input byte_q_t payload);
    byte_q_t     f;
    logic [31:0] fcs;
    f = {};
    repeat (7) begin
        f.push_back(8'h55);
    end
    f.push_back(8'hD5);
    foreach (payload[i]) begin
        f.push_back(payload[i]);
    end
    fcs = fcs_of(payload);
    for (int k = 0; k < 4; k++) begin
        f.push_back(fcs[8*k +: 8]);
    end
    return f;
endfunction

`endif

//--- tb/tb_mac_rx.sv
/*
 * Testbench for the RGMII receive MAC covering good and bad frames, receive
 * error, in-band link status, back-to-back frames and reset state
 */
module tb_mac_rx;
    timeunit 1ns;
    timeprecision 100ps;
    import mac_rx_pkg::*;

    `include "tb_frame_gen.svh"

    // first data byte follows 7 preamble bytes and the SFD
    localparam int DATA_POS = 8;
    localparam int LATENCY  = 4;
    localparam int WAIT_MAX = 200;
    localparam int GAP_CYC  = 12;

    logic         mac_rx_clk;
    logic         rst_n_i;
    rx_byte_t     rx_byte_i;
    rx_out_t      mac_rx_o;
    link_status_t status_o;

    integer       seed;
    int unsigned  cyc = 0;
    // cycle at which the first data byte is sampled
    int unsigned  first_cyc;
    logic [3:0]   gap_nibble;
    byte_q_t      base_payload;

    mac_rx_top UUT (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .rx_byte_i  (rx_byte_i),
        .mac_rx_o   (mac_rx_o),
        .status_o   (status_o)
    );

    initial begin
        mac_rx_clk = 1'b0;
        forever #2 mac_rx_clk = ~mac_rx_clk;
    end

    always @(posedge mac_rx_clk) cyc <= cyc + 1;

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s, got %h, expected %h",
                                $time, msg, got, exp));
        end
    endtask

    // ----------------------------------------
    // stimulus and collection
    // ----------------------------------------

    // gap bytes carry the status nibble with dv and er low
    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge mac_rx_clk);
            #1;
            rx_byte_i.data = {4'h0, gap_nibble};
            rx_byte_i.dv   = 1'b0;
            rx_byte_i.er   = 1'b0;
        end
    endtask

    // err_idx below zero means a clean frame
    task automatic drive_frame(input byte_q_t frame, input int err_idx);
        foreach (frame[i]) begin
            @(posedge mac_rx_clk);
            #1;
            rx_byte_i.data = frame[i];
            rx_byte_i.dv   = 1'b1;
            rx_byte_i.er   = (i == err_idx);
            if (i == DATA_POS) begin
                first_cyc = cyc + 1;
            end
        end
        drive_idle(GAP_CYC);
    endtask

    task automatic collect_frame(output byte_q_t data, output logic good, output logic err);
        int n;
        data = {};
        n    = 0;
        // the first valid byte must arrive on time with sof set
        do begin
            @(negedge mac_rx_clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run("timed out waiting for the first valid output byte");
            end
        end while (!mac_rx_o.valid);
        check(cyc, first_cyc + LATENCY, "latency of first data byte");
        n = 0;
        forever begin
            check(mac_rx_o.valid, 1'b1, "valid through the frame");
            check(mac_rx_o.sof, data.size() == 0, "sof only on first byte");
            data.push_back(mac_rx_o.data);
            if (mac_rx_o.eof) begin
                break;
            end
            check({mac_rx_o.fr_good, mac_rx_o.fr_err}, 2'b00, "verdict before eof");
            @(negedge mac_rx_clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run("timed out waiting for eof");
            end
        end
        good = mac_rx_o.fr_good;
        err  = mac_rx_o.fr_err;
        // output stays quiet for the rest of the gap
        repeat (GAP_CYC - LATENCY - 1) begin
            @(negedge mac_rx_clk);
            check({mac_rx_o.valid, mac_rx_o.sof, mac_rx_o.eof, mac_rx_o.fr_good,
                   mac_rx_o.fr_err}, 5'b0, "strobes low between frames");
        end
    endtask

    task automatic make_payload(input int len, output byte_q_t p);
        p = {};
        repeat (len) begin
            p.push_back(8'($random(seed)));
        end
    endtask

    // sends one frame and compares data and verdict
    task automatic run_frame(input byte_q_t payload, input bit bad_fcs, input int err_idx,
                             input string name);
        byte_q_t frame;
        byte_q_t exp_data;
        byte_q_t got;
        logic    good;
        logic    err;
        frame = build_frame(payload);
        if (bad_fcs) begin
            frame[frame.size()-1] ^= 8'h01;
        end
        exp_data = {};
        for (int i = DATA_POS; i < frame.size(); i++) begin
            exp_data.push_back(frame[i]);
        end
        fork
            drive_frame(frame, err_idx);
            collect_frame(got, good, err);
        join
        check(got.size(), exp_data.size(), {name, " byte count"});
        foreach (exp_data[i]) begin
            check(got[i], exp_data[i], {name, " data byte"});
        end
        check(good, !bad_fcs, {name, " fr_good"});
        check(err, err_idx >= DATA_POS, {name, " fr_err"});
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset();
        repeat (20) begin
            @(negedge mac_rx_clk);
            check({mac_rx_o.valid, mac_rx_o.sof, mac_rx_o.eof, mac_rx_o.fr_good,
                   mac_rx_o.fr_err}, 5'b0, "strobes after reset");
            check(status_o, 4'h0, "status after reset");
        end
    endtask

    task automatic test_link_status();
        logic [3:0] nib;
        for (int spd = 0; spd < 3; spd++) begin
            for (int bits = 0; bits < 4; bits++) begin
                // [3] full duplex, [2:1] speed code, [0] link up
                nib        = {bits[1], spd[1:0], bits[0]};
                gap_nibble = nib;
                drive_idle(8);
                @(negedge mac_rx_clk);
                check(status_o, nib, "link status nibble");
            end
        end
    endtask

    task automatic test_back_to_back();
        byte_q_t p;
        int      len;
        for (int k = 0; k < 3; k++) begin
            len = 64 + int'({$random(seed)} % 65);
            make_payload(len, p);
            // middle frame carries a broken FCS
            run_frame(p, k == 1, -1, $sformatf("back-to-back frame %0d", k));
        end
    endtask

    initial begin
        rx_byte_i  = '0;
        rst_n_i    = 1'b0;
        gap_nibble = 4'h0;
        seed       = 32'h5bc0_5b1f;
        first_cyc  = 0;
        repeat (10) @(posedge mac_rx_clk);
        #1;
        rst_n_i = 1'b1;

        test_reset();
        make_payload(60, base_payload);
        run_frame(base_payload, 1'b0, -1, "good frame");
        run_frame(base_payload, 1'b1, -1, "bad FCS");
        run_frame(base_payload, 1'b0, DATA_POS + 10, "receive error");
        test_link_status();
        test_back_to_back();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
hdl/eth_defs_pkg.sv
hdl/mac_rx_pkg.sv
hdl/rx_frame_parser.sv
hdl/rx_crc_check.sv
hdl/rx_align_buffer.sv
hdl/mac_rx_top.sv
tb/tb_mac_rx.sv
